// File: source/decodePkg.sv
package decodePkg;

	// ##################################################
	// Micro-commands

	// The header reference steps through the store, load, three-register
	// and two-operand groups by offset, so their order here matters
	typedef enum logic [7:0] {
		INVOP,
		MOVB_RM, MOVW_RM, MOVL_RM, MOVQ_RM,
		MOVB_MR, MOVW_MR, MOVL_MR, MOVQ_MR,
		MOVUB_MR, MOVUW_MR, MOVUL_MR,
		MOV_RR, MOV_IR,
		ADD, SUB, ADC, SBB,
		TST, TSTQ,
		AND, OR, XOR,
		MULS, MULU,
		CMPEQ, CMPQEQ, CMPHI, CMPQHI, CMPGT, CMPQGT,
		ADD3, SUB3, MUL3, AND3, OR3, XOR3,
		ADD2, SUB2, AND2, OR2, XOR2,
		LDISH16, LDISH32
	} uCmdE;

	// ##################################################
	// Decoder-internal classification

	// Operand form of a decoded row
	typedef enum logic [2:0] {
		FMID_INV, FMID_REGREG, FMID_REGSTREG, FMID_REGSTDRREG,
		FMID_LDREGREG, FMID_LDDRREGREG, FMID_IMM8REG
	} formIdE;

	// Immediate kind: signed, unsigned or ones-filled, by byte, word or long
	typedef enum logic [3:0] {
		ITY_NONE, ITY_SB, ITY_SW, ITY_SL, ITY_UB, ITY_UW, ITY_UL, ITY_NB, ITY_NW, ITY_NL
	} immTypeE;

	// Sizes sit at their uIxt codes, so the low two opcode bits map straight in
	typedef enum logic [2:0] {
		BTY_SB = 3'd0,
		BTY_SW = 3'd1,
		BTY_SL = 3'd2,
		BTY_SQ = 3'd3,
		BTY_UB = 3'd4,
		BTY_UW = 3'd5,
		BTY_NONE = 3'd7
	} accessSizeE;

	typedef enum logic [2:0] {
		IXT_REG, IXT_RDI, IXT_RRI, IXT_RDL
	} indexModeE;

	// ##################################################
	// Constants

	localparam logic [6:0] REG_ZZR = 7'h7F;
	localparam logic [6:0] REG_IMM = 7'h7E;

	// Byte address of the first instruction slot
	localparam logic [31:0] RESET_PC = 32'h0000_0400;

	// ##################################################
	// Structs

	// uIxt is {pad, index mode, load flag, access size}
	typedef struct packed {
		uCmdE        uCmd;
		logic [6:0]  regN;
		logic [6:0]  regM;
		logic [6:0]  regO;
		logic [31:0] imm;
		logic [7:0]  uIxt;
	} decodedOpT;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic [29:0] adr;
	} wbReqT;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wbRspT;

endpackage

// File: source/instrFetch.sv
`timescale 1ns/1ps

module instrFetch (
	input  logic             clock,
	input  logic             rstN,
	output decodePkg::wbReqT wbReq,
	input  decodePkg::wbRspT wbRsp,
	output logic [47:0]      instrWord,
	output logic             instrValid,
	input  logic             instrReady
);
	import decodePkg::*;

	typedef enum logic [1:0] {
		IDLE,
		READ_LOW,
		READ_HIGH,
		HOLD
	} fetchStateE;

	fetchStateE  state;
	logic        busActive;
	logic        ackSeen;
	logic [28:0] slotPc;
	logic [31:0] lowWord;

	// Each slot is 8 bytes; the second word of a slot holds bits 47:32
	assign wbReq.cyc = busActive;
	assign wbReq.stb = busActive;
	assign wbReq.adr = {slotPc, state == READ_HIGH};

	assign ackSeen = busActive && wbRsp.ack;
	assign instrValid = (state == HOLD);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
			busActive <= 1'b0;
			slotPc <= RESET_PC[31:3];
		end else begin
			case (state)
				IDLE: begin
					state <= READ_LOW;
					busActive <= 1'b1;
				end
				READ_LOW: begin
					if (ackSeen) begin
						state <= READ_HIGH;
						busActive <= 1'b0;
					end
				end
				READ_HIGH: begin
					// The bus stays idle for one cycle between the two reads
					if (!busActive) begin
						busActive <= 1'b1;
					end else if (ackSeen) begin
						state <= HOLD;
						busActive <= 1'b0;
					end
				end
				HOLD: begin
					if (instrReady) begin
						state <= READ_LOW;
						busActive <= 1'b1;
						slotPc <= slotPc + 29'd1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == READ_LOW && ackSeen)
			lowWord <= wbRsp.dat;
		if (state == READ_HIGH && ackSeen)
			instrWord <= {wbRsp.dat[15:0], lowWord};
	end

endmodule

// File: source/opDecoder.sv
`timescale 1ns/1ps

module opDecoder (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic [47:0]          instrWord,
	input  logic                 instrValid,
	output logic                 instrReady,
	output decodePkg::decodedOpT op,
	output logic                 opValid,
	input  logic                 opReady
);
	import decodePkg::*;

	decodedOpT  decOp;
	uCmdE       uCmd;
	formIdE     form;
	immTypeE    ity;
	accessSizeE bty;
	logic       exQ;
	logic       memRow;
	logic [3:0] memSel;
	logic       isLoad;
	logic [6:0] regNDfl;
	logic [6:0] regMDfl;
	logic [6:0] regODfl;

	// Bits 6:4 extend the N, M and O register fields to 5 bits
	assign exQ = instrWord[7];
	assign regNDfl = {2'b00, instrWord[6], instrWord[23:20]};
	assign regMDfl = {2'b00, instrWord[5], instrWord[19:16]};
	assign regODfl = {2'b00, instrWord[4], instrWord[3:0]};

	// ##################################################
	// Opcode selection

	always_comb begin
		uCmd = INVOP;
		form = FMID_INV;
		ity = ITY_NONE;
		bty = BTY_NONE;
		memRow = 1'b0;
		memSel = 4'h0;

		case (instrWord[11:8])
			4'h0: begin
				casez (instrWord[31:24])
					8'h0?: begin
						// Rows 00 to 0F carry a displacement or an index register
						memRow = 1'b1;
						memSel = instrWord[27:24];
						ity = ITY_UB;
					end
					8'h10, 8'h11, 8'h12, 8'h15, 8'h16, 8'h17: begin
						form = FMID_REGREG;
						case (instrWord[26:24])
							3'h0: uCmd = ADD3;
							3'h1: uCmd = SUB3;
							3'h2: uCmd = MUL3;
							3'h5: uCmd = AND3;
							3'h6: uCmd = OR3;
							default: uCmd = XOR3;
						endcase
					end
					8'h18: begin
						memRow = 1'b1;
						memSel = instrWord[3:0];
					end
					8'h19: begin
						form = FMID_REGREG;
						case (instrWord[3:0])
							4'h0: uCmd = ADD;
							4'h1: uCmd = SUB;
							4'h2: uCmd = ADC;
							4'h3: uCmd = SBB;
							4'h4: uCmd = exQ ? TSTQ : TST;
							4'h5: uCmd = AND;
							4'h6: uCmd = OR;
							4'h7: uCmd = XOR;
							4'h9: uCmd = MULS;
							4'hC: uCmd = exQ ? CMPQEQ : CMPEQ;
							4'hD: uCmd = exQ ? CMPQHI : CMPHI;
							4'hE: uCmd = exQ ? CMPQGT : CMPGT;
							4'hF: uCmd = MULU;
							default: uCmd = MOV_RR;
						endcase
					end
					8'h1D: begin
						case (instrWord[3:0])
							4'h8: uCmd = ADD2;
							4'h9: uCmd = SUB2;
							4'hA: uCmd = AND2;
							4'hB: uCmd = OR2;
							4'hC: uCmd = XOR2;
							default: uCmd = INVOP;
						endcase
						if (uCmd != INVOP)
							form = FMID_REGREG;
					end
					default: begin
					end
				endcase
			end
			4'h8: begin
				form = FMID_IMM8REG;
				case (instrWord[7:5])
					3'b000: begin
						uCmd = MOV_IR;
						ity = ITY_UW;
					end
					3'b001: begin
						uCmd = MOV_IR;
						ity = ITY_NW;
					end
					3'b010: begin
						uCmd = ADD;
						ity = ITY_SW;
					end
					3'b011: begin
						uCmd = LDISH16;
						ity = ITY_UW;
					end
					default: form = FMID_INV;
				endcase
			end
			4'hC, 4'hD: begin
				form = FMID_IMM8REG;
				case (instrWord[7:4])
					4'hC: begin
						uCmd = ADD;
						ity = ITY_SL;
					end
					4'hD: begin
						uCmd = LDISH32;
						ity = ITY_UL;
					end
					4'hE: begin
						uCmd = MOV_IR;
						ity = ITY_SL;
					end
					default: form = FMID_INV;
				endcase
			end
			default: begin
			end
		endcase

		// Memory rows share one layout with the form in bits 3:2 and the size in bits 1:0
		if (memRow) begin
			bty = accessSizeE'({1'b0, memSel[1:0]});
			case (memSel[3:2])
				2'b00: form = FMID_REGSTREG;
				2'b01: form = FMID_REGSTDRREG;
				2'b10: form = FMID_LDREGREG;
				default: form = FMID_LDDRREGREG;
			endcase
			case ({memSel[3], memSel[1:0]})
				3'b000: uCmd = MOVB_RM;
				3'b001: uCmd = MOVW_RM;
				3'b010: uCmd = MOVL_RM;
				3'b011: uCmd = MOVQ_RM;
				3'b100: uCmd = exQ ? MOVUB_MR : MOVB_MR;
				3'b101: uCmd = exQ ? MOVUW_MR : MOVW_MR;
				3'b110: uCmd = exQ ? MOVUL_MR : MOVL_MR;
				default: uCmd = MOVQ_MR;
			endcase
		end
	end

	// ##################################################
	// Operand assembly

	always_comb begin
		isLoad = (form == FMID_LDREGREG) || (form == FMID_LDDRREGREG);
		decOp.uCmd = uCmd;
		decOp.regN = REG_ZZR;
		decOp.regM = REG_ZZR;
		decOp.regO = REG_ZZR;
		decOp.imm = 32'h0;
		decOp.uIxt = 8'h00;

		case (form)
			FMID_REGREG: begin
				decOp.regN = regNDfl;
				decOp.regM = regMDfl;
				decOp.regO = regODfl;
			end
			FMID_REGSTREG, FMID_LDREGREG: begin
				decOp.regN = regNDfl;
				decOp.regM = regMDfl;
				if (ity == ITY_UB) begin
					decOp.imm = {27'h0, instrWord[4:0]};
					decOp.uIxt = {1'b0, IXT_RDI, isLoad, bty};
				end else begin
					decOp.uIxt = {1'b0, IXT_REG, isLoad, bty};
				end
			end
			FMID_REGSTDRREG, FMID_LDDRREGREG: begin
				decOp.regN = regNDfl;
				decOp.regM = regMDfl;
				if (ity == ITY_UB) begin
					decOp.regO = regODfl;
					decOp.uIxt = {1'b0, IXT_RRI, isLoad, bty};
				end else begin
					decOp.uIxt = {1'b0, IXT_RDL, isLoad, bty};
				end
			end
			FMID_IMM8REG: begin
				decOp.regN = regODfl;
				decOp.regM = REG_IMM;
				case (ity)
					ITY_SW: decOp.imm = {{16{instrWord[31]}}, instrWord[31:16]};
					ITY_UW: decOp.imm = {16'h0000, instrWord[31:16]};
					ITY_NW: decOp.imm = {16'hFFFF, instrWord[31:16]};
					ITY_SL, ITY_UL: decOp.imm = instrWord[47:16];
					default: decOp.imm = 32'h0;
				endcase
			end
			default: begin
			end
		endcase
	end

	// ##################################################
	// Output register

	// A full register still accepts a word in the cycle it is drained
	assign instrReady = !opValid || opReady;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			opValid <= 1'b0;
		else if (instrValid && instrReady)
			opValid <= 1'b1;
		else if (opReady)
			opValid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (instrValid && instrReady)
			op <= decOp;
	end

endmodule

// File: source/decodeFrontEnd.sv
`timescale 1ns/1ps

module decodeFrontEnd (
	input  logic                 clock,
	input  logic                 rstN,
	output decodePkg::wbReqT     wbReq,
	input  decodePkg::wbRspT     wbRsp,
	output decodePkg::decodedOpT op,
	output logic                 opValid,
	input  logic                 opReady
);
	logic [47:0] instrWord;
	logic        instrValid;
	logic        instrReady;

	// Two bus reads per slot assemble one 48-bit word
	instrFetch fetch (
		.clock      (clock),
		.rstN       (rstN),
		.wbReq      (wbReq),
		.wbRsp      (wbRsp),
		.instrWord  (instrWord),
		.instrValid (instrValid),
		.instrReady (instrReady)
	);

	opDecoder decoder (
		.clock      (clock),
		.rstN       (rstN),
		.instrWord  (instrWord),
		.instrValid (instrValid),
		.instrReady (instrReady),
		.op         (op),
		.opValid    (opValid),
		.opReady    (opReady)
	);

endmodule

// File: include/decodeRef.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Include inside the testbench module after importing decodePkg

// ##################################################
// Encoding builders

// Group 0 word: row in bits 31:24, Q bit, then the N, M and O fields with extensions
function automatic logic [47:0] encRow0(input logic [7:0] row, input logic q,
		input logic [4:0] n, input logic [4:0] m, input logic [4:0] o);
	return {16'h0000, row, n[3:0], m[3:0], 8'hF0, q, n[4], m[4], o};
endfunction

function automatic logic [47:0] encImm16(input logic [2:0] sel, input logic [4:0] n,
		input logic [15:0] imm);
	return {16'h0000, imm, 8'hF8, sel, n};
endfunction

// Bit 4 belongs to both the selector and the register, so n is 4 bits here
function automatic logic [47:0] encImm32(input logic [3:0] sel, input logic groupD,
		input logic [3:0] n, input logic [31:0] imm);
	return {imm, 4'hF, 3'b110, groupD, sel, n};
endfunction

// ##################################################
// Reference decoder

function automatic decodedOpT refDecode(input logic [47:0] w);
	decodedOpT  r;
	uCmdE       p19 [16];
	indexModeE  ix;
	logic [3:0] ms;
	logic       disp;
	logic       regs3;
	p19 = '{ADD, SUB, ADC, SBB, TST, AND, OR, XOR,
		MOV_RR, MULS, MOV_RR, MOV_RR, CMPEQ, CMPHI, CMPGT, MULU};
	r = '{INVOP, REG_ZZR, REG_ZZR, REG_ZZR, 32'h0, 8'h00};
	disp = (w[31:28] == 4'h0);
	regs3 = 1'b1;
	if (w[11:8] == 4'h0 && (disp || w[31:24] == 8'h18)) begin
		ms = disp ? w[27:24] : w[3:0];
		if (!ms[3])
			r.uCmd = uCmdE'(MOVB_RM + ms[1:0]);
		else if (w[7] && ms[1:0] != 2'b11)
			r.uCmd = uCmdE'(MOVUB_MR + ms[1:0]);
		else
			r.uCmd = uCmdE'(MOVB_MR + ms[1:0]);
		ix = disp ? (ms[2] ? IXT_RRI : IXT_RDI) : (ms[2] ? IXT_RDL : IXT_REG);
		r.uIxt = {1'b0, ix, ms[3], 1'b0, ms[1:0]};
		r.imm = (disp && !ms[2]) ? {27'h0, w[4:0]} : 32'h0;
		regs3 = disp && ms[2];
	end else if (w[11:8] == 4'h0 && w[31:24] inside {8'h10, 8'h11, 8'h12, 8'h15, 8'h16, 8'h17})
		r.uCmd = uCmdE'(ADD3 + (w[26] ? w[26:24] - 3'd2 : w[26:24]));
	else if (w[11:8] == 4'h0 && w[31:24] == 8'h19)
		r.uCmd = uCmdE'(p19[w[3:0]] + (w[7] && w[3:0] inside {4'h4, 4'hC, 4'hD, 4'hE}));
	else if (w[11:8] == 4'h0 && w[31:24] == 8'h1D && w[3:0] inside {[4'h8:4'hC]})
		r.uCmd = uCmdE'(ADD2 + w[2:0]);
	if (r.uCmd != INVOP) begin
		r.regN = {2'b00, w[6], w[23:20]};
		r.regM = {2'b00, w[5], w[19:16]};
		r.regO = regs3 ? {2'b00, w[4], w[3:0]} : REG_ZZR;
	end
	if (w[11:8] == 4'h8 && !w[7]) begin
		r.uCmd = w[6] ? (w[5] ? LDISH16 : ADD) : MOV_IR;
		r.imm[15:0] = w[31:16];
		r.imm[31:16] = (w[6:5] == 2'b01 || (w[6:5] == 2'b10 && w[31])) ? 16'hFFFF : 16'h0;
	end else if (w[11:9] == 3'b110 && w[7:4] inside {4'hC, 4'hD, 4'hE}) begin
		r.uCmd = (w[7:4] == 4'hC) ? ADD : ((w[7:4] == 4'hD) ? LDISH32 : MOV_IR);
		r.imm = w[47:16];
	end
	if (r.uCmd inside {MOV_IR, LDISH16, LDISH32} || (r.uCmd == ADD && w[11:8] != 4'h0)) begin
		r.regN = {2'b00, w[4], w[3:0]};
		r.regM = REG_IMM;
		r.regO = REG_ZZR;
	end
	return r;
endfunction

`endif

// File: verif/tbDecodeFrontEnd.sv
`timescale 1ns/1ps

module tbDecodeFrontEnd;
	import decodePkg::*;

	`include "decodeRef.svh"

	localparam int SLOTS = 200;

	logic        clock = 1'b0;
	logic        rstN;
	logic        opReady;
	wbReqT       wbReq;
	wbRspT       wbRsp;
	decodedOpT   op;
	logic        opValid;

	logic [47:0] prog [SLOTS];
	logic [2:0]  kind [SLOTS];
	string       familyName [8] = '{"memDisp", "memIndex", "alu3", "alu19", "alu2",
		"imm16", "imm32", "filler"};
	logic [31:0] lfsrState;
	logic [29:0] expAdr;
	logic [1:0]  ackWait;
	logic        reqOpen;
	logic        holdValid;
	decodedOpT   heldOp;
	int          received;
	int          decodeErrors;
	int          busErrors;
	int          flowErrors;
	int          waitCount;

	decodeFrontEnd dut (
		.clock   (clock),
		.rstN    (rstN),
		.wbReq   (wbReq),
		.wbRsp   (wbRsp),
		.op      (op),
		.opValid (opValid),
		.opReady (opReady)
	);

	always #5 clock = ~clock;

	// ##################################################
	// Stimulus

	// Fibonacci LFSR with taps at 32, 22, 2 and 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = 32'h0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// The low 16 bits of a hold q, n, m and o; b and c feed row selects and immediates
	task automatic buildProgram();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [7:0]  row;
		logic [7:0]  aluRows [6];
		aluRows = '{8'h10, 8'h11, 8'h12, 8'h15, 8'h16, 8'h17};
		for (int i = 0; i < SLOTS; i++) begin
			a = randBits(3);
			kind[i] = a[2:0];
			a = randBits(16);
			b = randBits(32);
			c = randBits(16);
			case (kind[i])
				3'd0: row = {4'h0, b[3:0]};
				3'd1: row = 8'h18;
				3'd2: row = aluRows[int'(b[7:0]) % 6];
				3'd3: row = 8'h19;
				default: row = 8'h1D;
			endcase
			if (kind[i] == 3'd5)
				prog[i] = encImm16(c[2:0], a[14:10], b[15:0]);
			else if (kind[i] == 3'd6)
				prog[i] = encImm32({2'b11, c[1:0]}, c[2], a[13:10], b);
			else if (kind[i] == 3'd7)
				prog[i] = {c[15:0], b};
			else
				prog[i] = encRow0(row, a[15], a[14:10], a[9:5], a[4:0]);
		end
	endtask

	// ##################################################
	// Memory model and back-pressure

	// Words past the program return a pattern built from the address
	function automatic logic [31:0] memRead(input logic [29:0] adr);
		logic [29:0] offset;
		int          slot;
		offset = adr - RESET_PC[31:2];
		slot = int'(offset[29:1]);
		if (slot >= SLOTS)
			return {adr, 2'b11} ^ 32'h5A5A_3C3C;
		if (adr[0])
			return {~adr[15:0], prog[slot][47:32]};
		return prog[slot][31:0];
	endfunction

	// Ack comes 0 to 3 cycles into a request and stays high for one cycle
	always @(negedge clock) begin
		logic [31:0] r;
		if (wbRsp.ack) begin
			wbRsp.ack = 1'b0;
			reqOpen = 1'b0;
			if (wbReq.cyc !== 1'b0 || wbReq.stb !== 1'b0) begin
				busErrors++;
				$display("Bus request still active in the cycle after ack");
			end
		end else if (wbReq.cyc && wbReq.stb) begin
			if (!reqOpen) begin
				r = randBits(2);
				ackWait = r[1:0];
				reqOpen = 1'b1;
				if (wbReq.adr !== expAdr) begin
					busErrors++;
					$display("MISMATCH busAddress: expected %h actual %h", expAdr, wbReq.adr);
				end
			end
			if (ackWait == 2'd0) begin
				wbRsp.ack = 1'b1;
				wbRsp.dat = memRead(wbReq.adr);
				expAdr = expAdr + 30'd1;
			end else begin
				ackWait = ackWait - 2'd1;
			end
		end
		// The execute side stops taking operations once the program is done
		r = randBits(2);
		opReady = (received < SLOTS) && (r[1:0] != 2'b00);
	end

	// ##################################################
	// Comparing process

	always @(posedge clock) begin
		decodedOpT refOp;
		if (rstN) begin
			if (holdValid && !opValid) begin
				decodeErrors++;
				$display("opValid dropped while the execute side was stalled");
			end else if (holdValid && op !== heldOp) begin
				decodeErrors++;
				$display("MISMATCH holdStable: expected %h actual %h", heldOp, op);
			end
			if (opValid && opReady) begin
				refOp = refDecode(prog[received]);
				if (op !== refOp) begin
					decodeErrors++;
					$display("MISMATCH %s slot %0d: expected %h actual %h",
						familyName[kind[received]], received, refOp, op);
				end
				received++;
			end
			holdValid = opValid && !opReady;
			heldOp = op;
		end
	end

	initial begin
		rstN = 1'b0;
		opReady = 1'b0;
		wbRsp = '0;
		lfsrState = 32'h4bcd_e119;
		expAdr = RESET_PC[31:2];
		ackWait = 2'd0;
		reqOpen = 1'b0;
		holdValid = 1'b0;
		received = 0;
		decodeErrors = 0;
		busErrors = 0;
		flowErrors = 0;
		buildProgram();

		repeat (8) begin
			@(negedge clock);
			if (wbReq.cyc !== 1'b0 || wbReq.stb !== 1'b0 || opValid !== 1'b0) begin
				flowErrors++;
				$display("Bus cycle or opValid active during reset");
			end
		end
		rstN = 1'b1;
		#1;
		if (wbReq.cyc !== 1'b0 || opValid !== 1'b0) begin
			flowErrors++;
			$display("Bus cycle or opValid active in the first cycle after reset");
		end

		waitCount = 0;
		while (!wbReq.cyc && waitCount < 20) begin
			@(negedge clock);
			waitCount++;
		end
		if (!wbReq.cyc) begin
			flowErrors++;
			$display("Timeout: no bus read started after reset");
		end

		waitCount = 0;
		while (received < SLOTS && waitCount < 20000) begin
			@(negedge clock);
			waitCount++;
		end
		if (received < SLOTS) begin
			flowErrors++;
			$display("Timeout: only %0d of %0d operations arrived", received, SLOTS);
		end

		$display("Errors: %0d decode, %0d bus, %0d flow", decodeErrors, busErrors, flowErrors);
		if (decodeErrors == 0 && busErrors == 0 && flowErrors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
source/decodePkg.sv
source/instrFetch.sv
source/opDecoder.sv
source/decodeFrontEnd.sv
verif/tbDecodeFrontEnd.sv

// File: Makefile
TOP := tbDecodeFrontEnd

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f source/*.sv include/*.svh verif/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only -Wall --timing --top-module decodeFrontEnd -f vlog.f

clean:
	rm -rf obj_dir
